// ==== logic/rvb_defs.svh ====
`ifndef RVB_DEFS_SVH
`define RVB_DEFS_SVH

// data path width
`define RVB_XLEN 64

// register file address width
`define RVB_RADDR_W 5

// data RAM depth in 64-bit words
`define RVB_DMEM_WORDS 256

// multiplier bits retired per cycle, XLEN / MUL_BITS busy cycles
`define RVB_MUL_BITS 8

// carried PC value out of reset
`define RVB_RESET_PC 64'h0000_0000_8000_0000

`endif

// ==== logic/rvb_pkg.sv ====
`include "rvb_defs.svh"

package rvb_pkg;

	typedef logic [`RVB_XLEN-1:0]              xlen_t;
	typedef logic [`RVB_RADDR_W-1:0]           raddr_t;
	typedef logic [`RVB_XLEN/8-1:0]            wmask_t;   // one bit per byte lane
	typedef logic [$clog2(`RVB_XLEN/8)-1:0]    lane_t;    // byte offset inside a word
	typedef logic [1:0]                        mem_size_t; // 0 byte .. 3 double

	typedef enum logic [3:0] {
		ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, MUL, LOAD, STORE
	} alu_op_e;

	typedef enum logic [1:0] {
		IDLE, RUN, DONE
	} mul_state_e;

	// decoded instruction entering execute
	typedef struct packed {
		xlen_t     pc;
		alu_op_e   op;
		xlen_t     src1;
		xlen_t     src2;
		xlen_t     imm;         // load/store offset
		logic      rd_wen;
		raddr_t    rd_addr;
		mem_size_t size;
		logic      is_unsigned; // zero extend on load
		logic      ebreak;
	} issue_bundle_t;

	// contents of the execute/memory register
	typedef struct packed {
		xlen_t     pc;
		xlen_t     alu_res;     // doubles as memory address
		xlen_t     st_data;     // already on its byte lane
		wmask_t    wmask;
		logic      st_flag;
		logic      ld_flag;
		mem_size_t ld_size;
		logic      ld_unsigned;
		logic      rd_wen;
		raddr_t    rd_addr;
		logic      ebreak;
	} exmem_bundle_t;

	typedef struct packed {
		logic   rd_wen;
		raddr_t rd_addr;
		xlen_t  rd_data;
		xlen_t  pc;
	} wb_bundle_t;

endpackage

// ==== logic/mul_iter.sv ====
`include "rvb_defs.svh"

module mul_iter import rvb_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  start_i,
	input  xlen_t a_i,
	input  xlen_t b_i,
	output logic  busy_o,
	output xlen_t prod_o
);
	localparam int STEPS = `RVB_XLEN / `RVB_MUL_BITS;
	localparam int CNT_W = $clog2(STEPS);

	mul_state_e       state_q;
	logic [CNT_W-1:0] cnt_q;
	xlen_t            acc_q;
	xlen_t            mcand_q;
	xlen_t            mplier_q;
	xlen_t            cur_acc;
	xlen_t            cur_mcand;
	xlen_t            cur_mplier;
	xlen_t            acc_nx;
	logic             run;

	// one slice of multiplier bits, added bit by bit
	function automatic xlen_t shift_add(input xlen_t acc, input xlen_t mcand,
	                                    input logic [`RVB_MUL_BITS-1:0] bits);
		xlen_t sum;
		sum = acc;
		for (int i = 0; i < `RVB_MUL_BITS; i++) begin
			if (bits[i]) begin
				sum = sum + (mcand << i);
			end
		end
		return sum;
	endfunction

	assign run = (state_q == RUN);

	// first slice is taken straight from the operands on the start edge
	assign cur_acc    = run ? acc_q : '0;
	assign cur_mcand  = run ? mcand_q : a_i;
	assign cur_mplier = run ? mplier_q : b_i;
	assign acc_nx     = shift_add(cur_acc, cur_mcand, cur_mplier[`RVB_MUL_BITS-1:0]);

	assign busy_o = run || (state_q == IDLE && start_i);
	assign prod_o = acc_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
			cnt_q   <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					if (start_i) begin
						state_q <= RUN;
						cnt_q   <= CNT_W'(1);
					end
				end
				RUN: begin
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == CNT_W'(STEPS - 1)) begin
						state_q <= DONE; // last slice retires this edge
					end
				end
				default: state_q <= IDLE; // DONE lasts exactly the acceptance cycle
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (busy_o) begin
			acc_q    <= acc_nx;
			mcand_q  <= cur_mcand << `RVB_MUL_BITS;
			mplier_q <= cur_mplier >> `RVB_MUL_BITS;
		end
	end

endmodule

// ==== logic/exec_stage.sv ====
`include "rvb_defs.svh"

module exec_stage import rvb_pkg::*; (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          issue_i,
	input  issue_bundle_t issue_bundle_i,
	output logic          stall_o,
	output logic          ex_valid_o,
	output exmem_bundle_t ex_bundle_o
);
	localparam int SHW = $clog2(`RVB_XLEN);

	logic   mul_start;
	xlen_t  mul_prod;
	xlen_t  addr;
	xlen_t  alu_res;
	lane_t  lane;
	wmask_t size_mask;
	logic   is_store;
	logic   [SHW-1:0] shamt;

	assign mul_start = issue_i && (issue_bundle_i.op == MUL);

	mul_iter u_mul (
		.clk     (clk),
		.rst_n   (rst_n),
		.start_i (mul_start),
		.a_i     (issue_bundle_i.src1),
		.b_i     (issue_bundle_i.src2),
		.busy_o  (stall_o),
		.prod_o  (mul_prod)
	);

	assign addr  = issue_bundle_i.src1 + issue_bundle_i.imm;
	assign shamt = issue_bundle_i.src2[SHW-1:0]; // rv64 uses low 6 bits
	assign lane  = addr[$bits(lane_t)-1:0];
	assign is_store = (issue_bundle_i.op == STORE);

	always_comb begin
		case (issue_bundle_i.op)
			ADD:         alu_res = issue_bundle_i.src1 + issue_bundle_i.src2;
			SUB:         alu_res = issue_bundle_i.src1 - issue_bundle_i.src2;
			AND:         alu_res = issue_bundle_i.src1 & issue_bundle_i.src2;
			OR:          alu_res = issue_bundle_i.src1 | issue_bundle_i.src2;
			XOR:         alu_res = issue_bundle_i.src1 ^ issue_bundle_i.src2;
			SLL:         alu_res = issue_bundle_i.src1 << shamt;
			SRL:         alu_res = issue_bundle_i.src1 >> shamt;
			SRA:         alu_res = xlen_t'($signed(issue_bundle_i.src1) >>> shamt);
			SLT:         alu_res = xlen_t'($signed(issue_bundle_i.src1) <
			                               $signed(issue_bundle_i.src2));
			MUL:         alu_res = mul_prod; // valid once stall drops
			LOAD, STORE: alu_res = addr;
			default:     alu_res = '0;
		endcase
	end

	always_comb begin
		case (issue_bundle_i.size)
			2'd0:    size_mask = 8'h01;
			2'd1:    size_mask = 8'h03;
			2'd2:    size_mask = 8'h0f;
			default: size_mask = 8'hff;
		endcase
	end

	assign ex_valid_o = issue_i && !stall_o;

	always_comb begin
		ex_bundle_o             = '0;
		ex_bundle_o.pc          = issue_bundle_i.pc;
		ex_bundle_o.alu_res     = alu_res;
		// store data and mask moved onto the addressed byte lane
		ex_bundle_o.st_data     = issue_bundle_i.src2 << {lane, 3'b000};
		ex_bundle_o.wmask       = is_store ? wmask_t'(size_mask << lane) : '0;
		ex_bundle_o.st_flag     = is_store;
		ex_bundle_o.ld_flag     = (issue_bundle_i.op == LOAD);
		ex_bundle_o.ld_size     = issue_bundle_i.size;
		ex_bundle_o.ld_unsigned = issue_bundle_i.is_unsigned;
		ex_bundle_o.rd_wen      = issue_bundle_i.rd_wen;
		ex_bundle_o.rd_addr     = issue_bundle_i.rd_addr;
		ex_bundle_o.ebreak      = issue_bundle_i.ebreak;
	end

endmodule

// ==== logic/ex_mem_regs.sv ====
`include "rvb_defs.svh"

module ex_mem_regs import rvb_pkg::*; (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          mul_stop_i,
	input  logic          ex_valid_i,
	input  exmem_bundle_t ex_bundle_i,
	output logic          mem_valid_o,
	output exmem_bundle_t mem_bundle_o
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_valid_o     <= 1'b0;
			mem_bundle_o    <= '0;
			mem_bundle_o.pc <= `RVB_RESET_PC;
		end else if (mul_stop_i) begin
			// bundle keeps its value, only the slot empties
			mem_valid_o <= 1'b0;
		end else begin
			mem_valid_o  <= ex_valid_i;
			mem_bundle_o <= ex_bundle_i;
		end
	end

endmodule

// ==== logic/mem_stage.sv ====
`include "rvb_defs.svh"

module mem_stage import rvb_pkg::*; (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          mem_valid_i,
	input  exmem_bundle_t mem_bundle_i,
	output logic          wb_valid_o,
	output wb_bundle_t    wb_o,
	output logic          halt_o
);
	localparam int IDX_W  = $clog2(`RVB_DMEM_WORDS);
	localparam int NBYTES = $bits(wmask_t);

	xlen_t            dmem [`RVB_DMEM_WORDS];
	logic [IDX_W-1:0] idx;
	lane_t            lane;
	xlen_t            rd_word;
	xlen_t            rd_sh;
	xlen_t            ld_val;
	logic             sext;
	wb_bundle_t       wb_nx;

	assign idx  = mem_bundle_i.alu_res[$bits(lane_t) +: IDX_W]; // word index
	assign lane = mem_bundle_i.alu_res[$bits(lane_t)-1:0];

	always_ff @(posedge clk) begin
		if (mem_valid_i && mem_bundle_i.st_flag) begin
			for (int i = 0; i < NBYTES; i++) begin
				if (mem_bundle_i.wmask[i]) begin
					dmem[idx][i*8 +: 8] <= mem_bundle_i.st_data[i*8 +: 8];
				end
			end
		end
	end

	assign rd_word = dmem[idx];
	assign rd_sh   = rd_word >> {lane, 3'b000}; // addressed lane down to bit 0
	assign sext    = !mem_bundle_i.ld_unsigned;

	always_comb begin
		case (mem_bundle_i.ld_size)
			2'd0:    ld_val = {{(`RVB_XLEN-8){sext & rd_sh[7]}}, rd_sh[7:0]};
			2'd1:    ld_val = {{(`RVB_XLEN-16){sext & rd_sh[15]}}, rd_sh[15:0]};
			2'd2:    ld_val = {{(`RVB_XLEN-32){sext & rd_sh[31]}}, rd_sh[31:0]};
			default: ld_val = rd_sh;
		endcase
	end

	always_comb begin
		wb_nx.rd_wen  = mem_bundle_i.rd_wen && !mem_bundle_i.st_flag; // stores write no register
		wb_nx.rd_addr = mem_bundle_i.rd_addr;
		wb_nx.rd_data = mem_bundle_i.ld_flag ? ld_val : mem_bundle_i.alu_res;
		wb_nx.pc      = mem_bundle_i.pc;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid_o <= 1'b0;
			halt_o     <= 1'b0;
		end else begin
			wb_valid_o <= mem_valid_i;
			if (mem_valid_i && mem_bundle_i.ebreak) begin
				halt_o <= 1'b1; // sticky until reset
			end
		end
	end

	always_ff @(posedge clk) begin
		if (mem_valid_i) begin
			wb_o <= wb_nx;
		end
	end

endmodule

// ==== logic/rvb_back_top.sv ====
`include "rvb_defs.svh"

module rvb_back_top import rvb_pkg::*; (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          issue_i,
	input  issue_bundle_t issue_bundle_i,
	output logic          stall_o,
	output logic          wb_valid_o,
	output wb_bundle_t    wb_o,
	output logic          halt_o
);
	logic          ex_valid;
	exmem_bundle_t ex_bundle;
	logic          mem_valid;
	exmem_bundle_t mem_bundle;

	exec_stage u_exec (
		.clk            (clk),
		.rst_n          (rst_n),
		.issue_i        (issue_i),
		.issue_bundle_i (issue_bundle_i),
		.stall_o        (stall_o),
		.ex_valid_o     (ex_valid),
		.ex_bundle_o    (ex_bundle)
	);

	// stall doubles as the multiplier stop for the pipeline register
	ex_mem_regs u_ex_mem (
		.clk          (clk),
		.rst_n        (rst_n),
		.mul_stop_i   (stall_o),
		.ex_valid_i   (ex_valid),
		.ex_bundle_i  (ex_bundle),
		.mem_valid_o  (mem_valid),
		.mem_bundle_o (mem_bundle)
	);

	mem_stage u_mem (
		.clk          (clk),
		.rst_n        (rst_n),
		.mem_valid_i  (mem_valid),
		.mem_bundle_i (mem_bundle),
		.wb_valid_o   (wb_valid_o),
		.wb_o         (wb_o),
		.halt_o       (halt_o)
	);

endmodule

// ==== sim/rvb_back_sva.sv ====
`include "rvb_defs.svh"

module rvb_back_sva (
	input logic clk,
	input logic rst_n,
	input logic issue_i,
	input logic stall_i,
	input logic wb_valid_i,
	input logic halt_i
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_STALL = `RVB_XLEN / `RVB_MUL_BITS + 1;

	logic [4:0] stall_cnt; // consecutive stalled cycles

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stall_cnt <= '0;
		end else if (stall_i) begin
			stall_cnt <= stall_cnt + 5'd1;
		end else begin
			stall_cnt <= '0;
		end
	end

	a_wb_latency: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid_i == $past(issue_i && !stall_i, 2))
		else $error("write-back strobe not two edges after acceptance");

	a_stall_bound: assert property (@(posedge clk) disable iff (!rst_n)
		stall_i |-> stall_cnt < 5'(MAX_STALL))
		else $error("stall held longer than the multiplier needs");

	a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		$past(halt_i) |-> halt_i)
		else $error("halt dropped before reset");

endmodule

bind rvb_back_top rvb_back_sva u_sva (
	.clk        (clk),
	.rst_n      (rst_n),
	.issue_i    (issue_i),
	.stall_i    (stall_o),
	.wb_valid_i (wb_valid_o),
	.halt_i     (halt_o)
);

// ==== sim/tb_rvb_back.sv ====
`include "rvb_defs.svh"

module tb_rvb_back import rvb_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	// one row of the stimulus table with its expected write-back
	typedef struct packed {
		issue_bundle_t bundle;
		logic          exp_wen;
		raddr_t        exp_addr;
		xlen_t         exp_data;
	} entry_t;

	logic          clk = 1'b0;
	logic          rst_n;
	logic          issue_i;
	issue_bundle_t issue_bundle_i;
	logic          stall_o;
	logic          wb_valid_o;
	wb_bundle_t    wb_o;
	logic          halt_o;

	entry_t tbl[$];
	entry_t exp_q[$];             // accepted and waiting for write-back
	logic   halt_exp = 1'b0;
	logic   tbl_ready = 1'b0;
	integer seed = 32'h1a5a66b6;

	rvb_back_top u_dut (.*);

	always #4 clk = ~clk;

	task automatic abort_run();
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_field(input string name, input xlen_t got, input xlen_t exp);
		assert (got === exp) else begin
			$display("[ERROR] %s: got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	// reference results from the rv64 integer rules
	function automatic xlen_t alu_ref(input alu_op_e op, input xlen_t a, input xlen_t b);
		logic [5:0] sh;
		xlen_t      fill;
		sh   = b[5:0];
		fill = a[63] ? ~({64{1'b1}} >> sh) : '0; // sign copies for sra
		case (op)
			ADD:     return a + b;
			SUB:     return a - b;
			AND:     return a & b;
			OR:      return a | b;
			XOR:     return a ^ b;
			SLL:     return a << sh;
			SRL:     return a >> sh;
			SRA:     return (a >> sh) | fill;
			SLT:     return {63'd0, $signed(a) < $signed(b)};
			MUL:     return a * b; // low 64 bits only
			default: return '0;
		endcase
	endfunction

	task automatic add_entry(input alu_op_e op, input xlen_t s1, input xlen_t s2,
	                         input xlen_t imm, input raddr_t rd, input mem_size_t size,
	                         input logic uns, input logic ebrk, input logic exp_wen,
	                         input xlen_t exp_data);
		entry_t e;
		e                    = '0;
		e.bundle.pc          = `RVB_RESET_PC + xlen_t'(4 * tbl.size());
		e.bundle.op          = op;
		e.bundle.src1        = s1;
		e.bundle.src2        = s2;
		e.bundle.imm         = imm;
		e.bundle.rd_wen      = 1'b1;
		e.bundle.rd_addr     = rd;
		e.bundle.size        = size;
		e.bundle.is_unsigned = uns;
		e.bundle.ebreak      = ebrk;
		e.exp_wen            = exp_wen;
		e.exp_addr           = rd;
		e.exp_data           = exp_data;
		tbl.push_back(e);
	endtask

	task automatic add_alu(input alu_op_e op, input xlen_t a, input xlen_t b, input raddr_t rd);
		add_entry(op, a, b, '0, rd, 2'd3, 1'b0, 1'b0, 1'b1, alu_ref(op, a, b));
	endtask

	// store asks for a register write that write-back must drop
	task automatic add_store(input xlen_t base, input xlen_t off, input xlen_t data,
	                         input mem_size_t size);
		add_entry(STORE, base, data, off, 5'd31, size, 1'b0, 1'b0, 1'b0, base + off);
	endtask

	task automatic add_load(input xlen_t base, input xlen_t off, input mem_size_t size,
	                        input logic uns, input raddr_t rd, input xlen_t exp);
		add_entry(LOAD, base, '0, off, rd, size, uns, 1'b0, 1'b1, exp);
	endtask

	task automatic issue_entry(input entry_t e);
		issue_bundle_i = e.bundle;
		issue_i        = 1'b1;
		#1;
		// a multiply raises stall at once and nothing else stalls
		check_field("stall_o", xlen_t'(stall_o), xlen_t'(e.bundle.op == MUL));
		while (stall_o) begin // hold the bundle while the multiplier is busy
			@(negedge clk);
			#1;
		end
		exp_q.push_back(e);
		@(negedge clk);
	endtask

	always @(negedge clk) begin : wb_monitor
		entry_t e;
		if (rst_n && wb_valid_o) begin
			if (exp_q.size() == 0) begin
				$display("write-back strobe seen with no instruction in flight");
				abort_run();
			end else begin
				e        = exp_q.pop_front();
				halt_exp = halt_exp | e.bundle.ebreak;
				check_field("wb_o.rd_wen", xlen_t'(wb_o.rd_wen), xlen_t'(e.exp_wen));
				check_field("wb_o.rd_addr", xlen_t'(wb_o.rd_addr), xlen_t'(e.exp_addr));
				check_field("wb_o.rd_data", wb_o.rd_data, e.exp_data);
				check_field("wb_o.pc", wb_o.pc, e.bundle.pc);
				check_field("halt_o", xlen_t'(halt_o), xlen_t'(halt_exp));
			end
		end
	end

	initial begin : watchdog
		wait (tbl_ready);
		repeat (16 + 20 * tbl.size()) @(posedge clk);
		$display("timeout: pipeline did not finish the table in time");
		abort_run();
	end

	initial begin : main
		xlen_t       a;
		xlen_t       b;
		int unsigned op_idx;
		rst_n          = 1'b0;
		issue_i        = 1'b0;
		issue_bundle_i = '0;
		add_alu(ADD, 64'd5, 64'd7, 5'd1);
		add_alu(SUB, 64'd3, 64'd10, 5'd2);
		add_alu(AND, 64'hff00_ff00_1234_5678, 64'h0ff0_0ff0_ffff_0000, 5'd3);
		add_alu(OR, 64'hf000_0000_0000_000f, 64'h0000_00f0_0f00_0000, 5'd4);
		add_alu(XOR, 64'haaaa_5555_aaaa_5555, 64'hffff_0000_ffff_0000, 5'd5);
		add_alu(SLL, 64'h1, 64'h7f, 5'd6); // amount wraps to 63
		add_alu(SRL, 64'h8000_0000_0000_0000, 64'd4, 5'd7);
		add_alu(SRA, 64'h8000_0000_0000_0000, 64'd4, 5'd8);
		add_alu(SLT, 64'hffff_ffff_ffff_ffff, 64'd1, 5'd9);
		add_alu(SLT, 64'd1, 64'hffff_ffff_ffff_ffff, 5'd10);
		add_alu(ADD, 64'd40, 64'd2, 5'd0);
		// multiplies with followers right behind
		add_alu(MUL, 64'h1234_5678_9abc_def0, 64'h0fed_cba9_8765_4321, 5'd11);
		add_alu(ADD, 64'd1, 64'd1, 5'd12);
		add_alu(MUL, 64'hffff_ffff_ffff_fffd, 64'd7, 5'd13);
		add_alu(MUL, 64'd0, 64'd12345, 5'd14);
		// word at 0x100 ends as 80001234_a566beef
		add_store(64'hf8, 64'h8, 64'h1122_3344_5566_7788, 2'd3);
		add_store(64'h100, 64'h4, 64'hdead_dead_8000_1234, 2'd2);
		add_store(64'h100, 64'h3, 64'hffff_ffff_ffff_ffa5, 2'd0);
		add_store(64'h100, 64'h0, 64'h1111_2222_3333_beef, 2'd1);
		add_load(64'h100, 64'h3, 2'd0, 1'b0, 5'd15, 64'hffff_ffff_ffff_ffa5);
		add_load(64'h100, 64'h3, 2'd0, 1'b1, 5'd16, 64'h0000_0000_0000_00a5);
		add_load(64'h100, 64'h2, 2'd0, 1'b1, 5'd17, 64'h0000_0000_0000_0066);
		add_load(64'h100, 64'h0, 2'd1, 1'b0, 5'd18, 64'hffff_ffff_ffff_beef);
		add_load(64'h100, 64'h0, 2'd1, 1'b1, 5'd19, 64'h0000_0000_0000_beef);
		add_load(64'h100, 64'h4, 2'd2, 1'b0, 5'd20, 64'hffff_ffff_8000_1234);
		add_load(64'h100, 64'h4, 2'd2, 1'b1, 5'd21, 64'h0000_0000_8000_1234);
		add_load(64'h100, 64'h0, 2'd2, 1'b0, 5'd22, 64'hffff_ffff_a566_beef);
		add_load(64'hf0, 64'h10, 2'd3, 1'b0, 5'd23, 64'h8000_1234_a566_beef);
		add_entry(ADD, 64'd1, 64'd2, '0, 5'd24, 2'd3, 1'b0, 1'b1, 1'b1, 64'd3); // ebreak
		for (int i = 0; i < 24; i++) begin
			op_idx = {$random(seed)} % 10; // ADD through MUL
			a      = {$random(seed), $random(seed)};
			b      = {$random(seed), $random(seed)};
			add_alu(alu_op_e'(op_idx[3:0]), a, b, raddr_t'($random(seed)));
		end
		tbl_ready = 1'b1;

		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (3) begin
			@(negedge clk);
			check_field("wb_valid_o", xlen_t'(wb_valid_o), '0);
			check_field("stall_o", xlen_t'(stall_o), '0);
			check_field("halt_o", xlen_t'(halt_o), '0);
		end

		foreach (tbl[i]) begin
			issue_entry(tbl[i]);
		end
		issue_i        = 1'b0;
		issue_bundle_i = '0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk); // catch late duplicates
		check_field("halt_o", xlen_t'(halt_o), 64'd1);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+logic
logic/rvb_pkg.sv
logic/mul_iter.sv
logic/exec_stage.sv
logic/ex_mem_regs.sv
logic/mem_stage.sv
logic/rvb_back_top.sv
sim/rvb_back_sva.sv
sim/tb_rvb_back.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_rvb_back -Mdir obj_dir
./obj_dir/Vtb_rvb_back
